/* common/ex_pkg.sv */
package ex_pkg;

  // Datapath widths
  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 6;   // GPR plus FP bank select

  ////////////////////////////////////////////////////////////////////////////
  // ALU opcodes

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,   // Branch comparisons from here on
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier opcodes

  typedef enum logic [1:0] {
    MULT_MUL   = 2'd0,
    MULT_MAC   = 2'd1,
    MULT_DOT8  = 2'd2,  // Four signed byte lanes
    MULT_DOT16 = 2'd3   // Two signed halfword lanes
  } mult_op_e;

endpackage

/* common/rnn_pkg.sv */
package rnn_pkg;

  // Special-purpose registers of the network extension
  localparam int unsigned n_wspr = 4;   // Weight registers
  localparam int unsigned n_aspr = 2;   // Activation registers

  localparam int unsigned wspr_sel_w = 2;
  localparam int unsigned aspr_sel_w = 1;

  // Load target fields from the decoder
  // Bit 0 is the write enable, the upper bits pick the register
  localparam int unsigned tosprw_w = 3;
  localparam int unsigned tospra_w = 2;

endpackage

/* source/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_op_e            operator_i,
  input  logic [ex_pkg::xlen-1:0]    operand_a_i,
  input  logic [ex_pkg::xlen-1:0]    operand_b_i,
  output logic [ex_pkg::xlen-1:0]    result_o,
  output logic                       comparison_result_o
);

  import ex_pkg::*;

  logic [4:0] shamt;
  logic       is_equal;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b_i[4:0];
  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  // Branch comparison, only meaningful for the branch opcodes
  always_comb begin
    case (operator_i)
      ALU_EQ:  comparison_result_o = is_equal;
      ALU_NE:  comparison_result_o = ~is_equal;
      ALU_LT:  comparison_result_o = lt_signed;
      ALU_GE:  comparison_result_o = ~lt_signed;
      default: comparison_result_o = 1'b0;
    endcase
  end

  always_comb begin
    case (operator_i)
      ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      ALU_SLT:  result_o = {{(xlen-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(xlen-1){1'b0}}, lt_unsigned};
      // Comparisons also land in bit 0 of the result
      ALU_EQ, ALU_NE, ALU_LT, ALU_GE: begin
        result_o = {{(xlen-1){1'b0}}, comparison_result_o};
      end
      default:  result_o = '0;
    endcase
  end

endmodule

/* mult/ex_mult.sv */
`timescale 1ns/1ps

module ex_mult (
  input  ex_pkg::mult_op_e           operator_i,
  input  logic [ex_pkg::xlen-1:0]    op_a_i,
  input  logic [ex_pkg::xlen-1:0]    op_b_i,
  input  logic [ex_pkg::xlen-1:0]    op_c_i,
  input  logic [ex_pkg::xlen-1:0]    dot_op_a_i,
  input  logic [ex_pkg::xlen-1:0]    dot_op_b_i,
  input  logic                       dot_spr_operand_i,
  input  logic [ex_pkg::xlen-1:0]    wspr_i,
  input  logic [ex_pkg::xlen-1:0]    aspr_i,
  output logic [ex_pkg::xlen-1:0]    result_o
);

  import ex_pkg::*;

  logic        [xlen-1:0] dot_a;
  logic        [xlen-1:0] dot_b;
  logic        [xlen-1:0] mul_low;
  logic signed [xlen-1:0] dot8_sum;
  logic signed [xlen-1:0] dot16_sum;

  // Activations on a, weights on b when the SPRs feed the dot product
  assign dot_a = dot_spr_operand_i ? aspr_i : dot_op_a_i;
  assign dot_b = dot_spr_operand_i ? wspr_i : dot_op_b_i;

  assign mul_low = op_a_i * op_b_i;   // Low word only

  ////////////////////////////////////////////////////////////////////////////
  // Packed signed dot products

  always_comb begin : dot8_lanes
    logic signed [15:0] lane_prod;
    dot8_sum = $signed(op_c_i);
    for (int i = 0; i < 4; i++) begin
      lane_prod = $signed(dot_a[8*i +: 8]) * $signed(dot_b[8*i +: 8]);
      dot8_sum  = dot8_sum + lane_prod;   // Sign extends to 32 bits
    end
  end

  always_comb begin : dot16_lanes
    logic signed [31:0] lane_prod;
    dot16_sum = $signed(op_c_i);
    for (int i = 0; i < 2; i++) begin
      lane_prod = $signed(dot_a[16*i +: 16]) * $signed(dot_b[16*i +: 16]);
      dot16_sum = dot16_sum + lane_prod;
    end
  end

  always_comb begin
    case (operator_i)
      MULT_MUL:   result_o = mul_low;
      MULT_MAC:   result_o = mul_low + op_c_i;
      MULT_DOT8:  result_o = $unsigned(dot8_sum);
      MULT_DOT16: result_o = $unsigned(dot16_sum);
      default:    result_o = '0;
    endcase
  end

endmodule

/* source/rnn_spr_file.sv */
`timescale 1ns/1ps

module rnn_spr_file (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [ex_pkg::xlen-1:0]          wdata_i,
  input  logic                             wspr_we_i,
  input  logic [rnn_pkg::wspr_sel_w-1:0]   wspr_waddr_i,
  input  logic                             aspr_we_i,
  input  logic [rnn_pkg::aspr_sel_w-1:0]   aspr_waddr_i,
  input  logic [rnn_pkg::wspr_sel_w-1:0]   wspr_raddr_i,
  input  logic [rnn_pkg::aspr_sel_w-1:0]   aspr_raddr_i,
  output logic [ex_pkg::xlen-1:0]          wspr_o,
  output logic [ex_pkg::xlen-1:0]          aspr_o
);

  import ex_pkg::*;
  import rnn_pkg::*;

  logic [xlen-1:0] wspr_q [n_wspr];
  logic [xlen-1:0] aspr_q [n_aspr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < n_wspr; i++) begin
        wspr_q[i] <= '0;
      end
      for (int i = 0; i < n_aspr; i++) begin
        aspr_q[i] <= '0;
      end
    end else begin
      if (wspr_we_i) wspr_q[wspr_waddr_i] <= wdata_i;   // Weight load
      if (aspr_we_i) aspr_q[aspr_waddr_i] <= wdata_i;   // Activation load
    end
  end

  // Read ports feed the dot product directly
  assign wspr_o = wspr_q[wspr_raddr_i];
  assign aspr_o = aspr_q[aspr_raddr_i];

endmodule

/* source/ex_writeback.sv */
`timescale 1ns/1ps

module ex_writeback (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             alu_en_i,
  input  logic                             mult_en_i,
  input  logic                             csr_access_i,
  input  logic                             lsu_en_i,
  input  logic                             dot_spr_operand_i,
  input  logic [ex_pkg::xlen-1:0]          alu_result_i,
  input  logic [ex_pkg::xlen-1:0]          mult_result_i,
  input  logic [ex_pkg::xlen-1:0]          csr_rdata_i,
  input  logic                             regfile_alu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0]    regfile_alu_waddr_i,
  input  logic                             regfile_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0]    regfile_waddr_i,
  input  logic [rnn_pkg::tosprw_w-1:0]     lsu_tosprw_ex_i,
  input  logic [rnn_pkg::tospra_w-1:0]     lsu_tospra_ex_i,
  input  logic [ex_pkg::xlen-1:0]          lsu_rdata_i,
  input  logic                             lsu_err_i,
  input  logic                             lsu_ready_ex_i,
  input  logic                             wb_ready_i,
  input  logic                             branch_in_ex_i,
  output logic                             regfile_alu_we_fw_o,
  output logic [ex_pkg::reg_addr_w-1:0]    regfile_alu_waddr_fw_o,
  output logic [ex_pkg::xlen-1:0]          regfile_alu_wdata_fw_o,
  output logic                             regfile_we_wb_o,
  output logic [ex_pkg::reg_addr_w-1:0]    regfile_waddr_wb_o,
  output logic [ex_pkg::xlen-1:0]          regfile_wdata_wb_o,
  output logic                             wspr_we_o,
  output logic [rnn_pkg::wspr_sel_w-1:0]   wspr_waddr_o,
  output logic                             aspr_we_o,
  output logic [rnn_pkg::aspr_sel_w-1:0]   aspr_waddr_o,
  output logic                             compute_load_vliw_o,
  output logic                             ex_ready_o,
  output logic                             ex_valid_o
);

  import ex_pkg::*;
  import rnn_pkg::*;

  logic                  load_compute;
  logic                  regfile_we_lsu;
  logic [reg_addr_w-1:0] regfile_waddr_lsu;
  logic [tosprw_w-1:0]   tosprw_wb;
  logic [tospra_w-1:0]   tospra_wb;
  logic                  dot_spr_operand_wb;
  logic [xlen-1:0]       mult_result_q;

  // Dot on SPRs issued alongside a load
  assign load_compute        = dot_spr_operand_i & mult_en_i;
  assign compute_load_vliw_o = load_compute;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding port

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (load_compute) begin
      regfile_alu_wdata_fw_o = alu_result_i;   // Dot result goes out via WB
    end else if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu     <= 1'b0;
      regfile_waddr_lsu  <= '0;
      tosprw_wb          <= '0;
      tospra_wb          <= '0;
      dot_spr_operand_wb <= 1'b0;
      mult_result_q      <= '0;
    end else if (ex_valid_o) begin
      regfile_we_lsu     <= regfile_we_i & ~lsu_err_i;
      tosprw_wb          <= lsu_tosprw_ex_i;
      tospra_wb          <= lsu_tospra_ex_i;
      dot_spr_operand_wb <= dot_spr_operand_i;
      mult_result_q      <= mult_result_i;
      if (regfile_we_i && !lsu_err_i) begin
        regfile_waddr_lsu <= regfile_waddr_i;   // Keep last good load address
      end
    end else if (wb_ready_i) begin
      regfile_we_lsu <= 1'b0;   // Bubble into WB
    end
  end

  // WB port, load data or the delayed dot result
  assign regfile_we_wb_o    = regfile_we_lsu;
  assign regfile_waddr_wb_o = regfile_waddr_lsu;
  assign regfile_wdata_wb_o = dot_spr_operand_wb ? mult_result_q : lsu_rdata_i;

  // SPR strobes, load data is written at the end of the WB cycle
  assign wspr_we_o    = regfile_we_lsu & tosprw_wb[0];
  assign wspr_waddr_o = tosprw_wb[tosprw_w-1:1];
  assign aspr_we_o    = regfile_we_lsu & tospra_wb[0];
  assign aspr_waddr_o = tospra_wb[tospra_w-1:1];

  // Branches finish here, so ready ignores the downstream stall for them
  assign ex_ready_o = (lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & lsu_ready_ex_i & wb_ready_i;

endmodule

/* source/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
  input  logic                             clk,
  input  logic                             rst_n,
  // ALU from ID
  input  ex_pkg::alu_op_e                  alu_operator_i,
  input  logic [ex_pkg::xlen-1:0]          alu_operand_a_i,
  input  logic [ex_pkg::xlen-1:0]          alu_operand_b_i,
  input  logic [ex_pkg::xlen-1:0]          alu_operand_c_i,
  input  logic                             alu_en_i,
  // Multiplier from ID
  input  ex_pkg::mult_op_e                 mult_operator_i,
  input  logic [ex_pkg::xlen-1:0]          mult_operand_a_i,
  input  logic [ex_pkg::xlen-1:0]          mult_operand_b_i,
  input  logic [ex_pkg::xlen-1:0]          mult_operand_c_i,
  input  logic                             mult_en_i,
  input  logic [ex_pkg::xlen-1:0]          mult_dot_op_a_i,
  input  logic [ex_pkg::xlen-1:0]          mult_dot_op_b_i,
  input  logic                             dot_spr_operand_i,
  // LSU
  input  logic                             lsu_en_i,
  input  logic [ex_pkg::xlen-1:0]          lsu_rdata_i,
  input  logic [rnn_pkg::tosprw_w-1:0]     lsu_tosprw_ex_i,
  input  logic [rnn_pkg::tospra_w-1:0]     lsu_tospra_ex_i,
  input  logic                             lsu_ready_ex_i,
  input  logic                             lsu_err_i,
  output logic                             compute_load_vliw_o,
  // Register file controls
  input  logic                             branch_in_ex_i,
  input  logic [ex_pkg::reg_addr_w-1:0]    regfile_alu_waddr_i,
  input  logic                             regfile_alu_we_i,
  input  logic                             regfile_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0]    regfile_waddr_i,
  input  logic                             csr_access_i,
  input  logic [ex_pkg::xlen-1:0]          csr_rdata_i,
  // To WB
  output logic [ex_pkg::reg_addr_w-1:0]    regfile_waddr_wb_o,
  output logic                             regfile_we_wb_o,
  output logic [ex_pkg::xlen-1:0]          regfile_wdata_wb_o,
  // Forwarding to ID
  output logic [ex_pkg::reg_addr_w-1:0]    regfile_alu_waddr_fw_o,
  output logic                             regfile_alu_we_fw_o,
  output logic [ex_pkg::xlen-1:0]          regfile_alu_wdata_fw_o,
  // To IF
  output logic [ex_pkg::xlen-1:0]          jump_target_o,
  output logic                             branch_decision_o,
  // Stall control
  output logic                             ex_ready_o,
  output logic                             ex_valid_o,
  input  logic                             wb_ready_i
);

  import ex_pkg::*;
  import rnn_pkg::*;

  logic [xlen-1:0]       alu_result;
  logic                  alu_cmp_result;
  logic [xlen-1:0]       mult_result;
  logic [xlen-1:0]       wspr;
  logic [xlen-1:0]       aspr;
  logic                  wspr_we;
  logic [wspr_sel_w-1:0] wspr_waddr;
  logic                  aspr_we;
  logic [aspr_sel_w-1:0] aspr_waddr;

  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ex_alu u_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .operator_i        (mult_operator_i),
    .op_a_i            (mult_operand_a_i),
    .op_b_i            (mult_operand_b_i),
    .op_c_i            (mult_operand_c_i),
    .dot_op_a_i        (mult_dot_op_a_i),
    .dot_op_b_i        (mult_dot_op_b_i),
    .dot_spr_operand_i (dot_spr_operand_i),
    .wspr_i            (wspr),
    .aspr_i            (aspr),
    .result_o          (mult_result)
  );

  // SPR read index comes from the target fields of the current instruction
  rnn_spr_file u_spr (
    .clk          (clk),
    .rst_n        (rst_n),
    .wdata_i      (lsu_rdata_i),
    .wspr_we_i    (wspr_we),
    .wspr_waddr_i (wspr_waddr),
    .aspr_we_i    (aspr_we),
    .aspr_waddr_i (aspr_waddr),
    .wspr_raddr_i (lsu_tosprw_ex_i[tosprw_w-1:1]),
    .aspr_raddr_i (lsu_tospra_ex_i[tospra_w-1:1]),
    .wspr_o       (wspr),
    .aspr_o       (aspr)
  );

  ex_writeback u_wb (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .dot_spr_operand_i      (dot_spr_operand_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_tosprw_ex_i        (lsu_tosprw_ex_i),
    .lsu_tospra_ex_i        (lsu_tospra_ex_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_err_i              (lsu_err_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .wspr_we_o              (wspr_we),
    .wspr_waddr_o           (wspr_waddr),
    .aspr_we_o              (aspr_we),
    .aspr_waddr_o           (aspr_waddr),
    .compute_load_vliw_o    (compute_load_vliw_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

/* verification/ex_stage_chk.sv */
`timescale 1ns/1ps

module ex_stage_chk (
  input logic clk,
  input logic rst_n,
  input logic wb_ready_i,
  input logic lsu_err_i,
  input logic branch_in_ex_i,
  input logic ex_valid_i,
  input logic ex_ready_i,
  input logic regfile_we_wb_i
);

  // Nothing leaves EX while WB stalls, and the WB register holds
  a_no_valid_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> !$past(ex_valid_i) && $stable(regfile_we_wb_i))
    else $error("ex_valid_o high or WB not held while wb_ready_i is low");

  a_err_drops_we: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i && lsu_err_i |=> !regfile_we_wb_i)
    else $error("regfile_we_wb_o set after a load error");

  a_branch_ready: assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex_i |-> ex_ready_i)   // Branches resolve in EX
    else $error("ex_ready_o low with a branch in EX");

endmodule

bind ex_stage ex_stage_chk u_chk (
  .clk             (clk),
  .rst_n           (rst_n),
  .wb_ready_i      (wb_ready_i),
  .lsu_err_i       (lsu_err_i),
  .branch_in_ex_i  (branch_in_ex_i),
  .ex_valid_i      (ex_valid_o),
  .ex_ready_i      (ex_ready_o),
  .regfile_we_wb_i (regfile_we_wb_o)
);

/* verification/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage;

  import ex_pkg::*;
  import rnn_pkg::*;

  localparam int unsigned max_cycles = 400;   // About 45 test cycles, wide margin

  logic                  clk;
  logic                  rst_n;
  alu_op_e               alu_operator_i;
  logic [xlen-1:0]       alu_operand_a_i;
  logic [xlen-1:0]       alu_operand_b_i;
  logic [xlen-1:0]       alu_operand_c_i;
  logic                  alu_en_i;
  mult_op_e              mult_operator_i;
  logic [xlen-1:0]       mult_operand_a_i;
  logic [xlen-1:0]       mult_operand_b_i;
  logic [xlen-1:0]       mult_operand_c_i;
  logic                  mult_en_i;
  logic [xlen-1:0]       mult_dot_op_a_i;
  logic [xlen-1:0]       mult_dot_op_b_i;
  logic                  dot_spr_operand_i;
  logic                  lsu_en_i;
  logic [xlen-1:0]       lsu_rdata_i;
  logic [tosprw_w-1:0]   lsu_tosprw_ex_i;
  logic [tospra_w-1:0]   lsu_tospra_ex_i;
  logic                  lsu_ready_ex_i;
  logic                  lsu_err_i;
  logic                  compute_load_vliw_o;
  logic                  branch_in_ex_i;
  logic [reg_addr_w-1:0] regfile_alu_waddr_i;
  logic                  regfile_alu_we_i;
  logic                  regfile_we_i;
  logic [reg_addr_w-1:0] regfile_waddr_i;
  logic                  csr_access_i;
  logic [xlen-1:0]       csr_rdata_i;
  logic [reg_addr_w-1:0] regfile_waddr_wb_o;
  logic                  regfile_we_wb_o;
  logic [xlen-1:0]       regfile_wdata_wb_o;
  logic [reg_addr_w-1:0] regfile_alu_waddr_fw_o;
  logic                  regfile_alu_we_fw_o;
  logic [xlen-1:0]       regfile_alu_wdata_fw_o;
  logic [xlen-1:0]       jump_target_o;
  logic                  branch_decision_o;
  logic                  ex_ready_o;
  logic                  ex_valid_o;
  logic                  wb_ready_i;

  int unsigned           cycle_cnt = 0;
  logic [xlen-1:0]       weight_val;   // Loaded into weight SPR 2
  logic [xlen-1:0]       act_val;      // Loaded into activation SPR 1

  ex_stage u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles) begin
      $display("TIMEOUT: run went past %0d clock cycles", max_cycles);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference models and checking

  function automatic logic cmp_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic lt;
    lt = (a[31] != b[31]) ? a[31] : (a < b);   // Differing signs, negative one is less
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return lt;
      ALU_GE:  return !lt;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    logic       ltu;
    sh  = b[4:0];
    ltu = a < b;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
      ALU_SLT:  return {31'd0, cmp_ref(ALU_LT, a, b)};
      ALU_SLTU: return {31'd0, ltu};
      default:  return {31'd0, cmp_ref(op, a, b)};
    endcase
  endfunction

  // Packed signed lanes summed onto c, wrapping at 32 bits
  function automatic logic [31:0] dot_ref(logic dot8, logic [31:0] a, logic [31:0] b,
                                          logic [31:0] c);
    int      sum;
    byte     sa;
    byte     sb;
    shortint ha;
    shortint hb;
    sum = c;
    if (dot8) begin
      for (int i = 0; i < 4; i++) begin
        sa  = a[8*i +: 8];
        sb  = b[8*i +: 8];
        sum = sum + int'(sa) * int'(sb);
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        ha  = a[16*i +: 16];
        hb  = b[16*i +: 16];
        sum = sum + int'(ha) * int'(hb);
      end
    end
    return sum;
  endfunction

  function automatic logic [31:0] mult_ref(mult_op_e op, logic [31:0] a, logic [31:0] b,
                                           logic [31:0] c, logic [31:0] da,
                                           logic [31:0] db);
    longint unsigned prod;
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      MULT_MUL:  return prod[31:0];
      MULT_MAC:  return prod[31:0] + c;
      MULT_DOT8: return dot_ref(1'b1, da, db, c);
      default:   return dot_ref(1'b0, da, db, c);
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at time %0t: %s got %08h expected %08h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // Bubble on every control, both ready inputs high
  task automatic idle_inputs();
    alu_operator_i      <= ALU_ADD;
    alu_operand_a_i     <= '0;
    alu_operand_b_i     <= '0;
    alu_operand_c_i     <= '0;
    alu_en_i            <= 1'b0;
    mult_operator_i     <= MULT_MUL;
    mult_operand_a_i    <= '0;
    mult_operand_b_i    <= '0;
    mult_operand_c_i    <= '0;
    mult_en_i           <= 1'b0;
    mult_dot_op_a_i     <= '0;
    mult_dot_op_b_i     <= '0;
    dot_spr_operand_i   <= 1'b0;
    lsu_en_i            <= 1'b0;
    lsu_rdata_i         <= '0;
    lsu_tosprw_ex_i     <= '0;
    lsu_tospra_ex_i     <= '0;
    lsu_ready_ex_i      <= 1'b1;
    lsu_err_i           <= 1'b0;
    branch_in_ex_i      <= 1'b0;
    regfile_alu_waddr_i <= '0;
    regfile_alu_we_i    <= 1'b0;
    regfile_we_i        <= 1'b0;
    regfile_waddr_i     <= '0;
    csr_access_i        <= 1'b0;
    csr_rdata_i         <= '0;
    wb_ready_i          <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_alu_ops();
    alu_op_e         op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] c;
    for (int k = 0; k < 14; k++) begin
      op = alu_op_e'(k);
      a  = $urandom;
      b  = (op == ALU_EQ) ? a : $urandom;   // Equal pair so EQ goes true
      c  = $urandom;
      @(posedge clk);
      idle_inputs();
      alu_en_i            <= 1'b1;
      alu_operator_i      <= op;
      alu_operand_a_i     <= a;
      alu_operand_b_i     <= b;
      alu_operand_c_i     <= c;
      regfile_alu_we_i    <= (k % 2 == 0);   // Toggles so both levels are seen
      regfile_alu_waddr_i <= 6'(k);
      @(negedge clk);
      check_value($sformatf("alu %s", op.name()), regfile_alu_wdata_fw_o, alu_ref(op, a, b));
      check_value("branch decision", 32'(branch_decision_o), 32'(cmp_ref(op, a, b)));
      check_value("jump target", jump_target_o, c);
      check_value("fw we", 32'(regfile_alu_we_fw_o), 32'(k % 2 == 0));
      check_value("fw waddr", 32'(regfile_alu_waddr_fw_o), k);
    end
  endtask

  task automatic test_mult_ops();
    mult_op_e        op;
    logic [xlen-1:0] v [5];
    for (int k = 0; k < 4; k++) begin
      op = mult_op_e'(k);
      foreach (v[i]) v[i] = $urandom;
      @(posedge clk);
      idle_inputs();
      mult_en_i        <= 1'b1;
      mult_operator_i  <= op;
      mult_operand_a_i <= v[0];
      mult_operand_b_i <= v[1];
      mult_operand_c_i <= v[2];
      mult_dot_op_a_i  <= v[3];
      mult_dot_op_b_i  <= v[4];
      @(negedge clk);
      check_value($sformatf("mult %s", op.name()), regfile_alu_wdata_fw_o,
                  mult_ref(op, v[0], v[1], v[2], v[3], v[4]));
    end
    @(posedge clk);
    csr_access_i <= 1'b1;   // CSR wins over the still enabled multiplier
    csr_rdata_i  <= v[0] ^ v[4];
    @(negedge clk);
    check_value("csr forward", regfile_alu_wdata_fw_o, v[0] ^ v[4]);
  endtask

  task automatic test_spr_load();
    logic [xlen-1:0] c;
    weight_val = $urandom;
    act_val    = $urandom;
    c          = $urandom;
    @(posedge clk);
    idle_inputs();
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= 6'd5;
    lsu_tosprw_ex_i <= {2'd2, 1'b1};   // Weight SPR 2
    @(posedge clk);
    idle_inputs();
    lsu_rdata_i <= weight_val;          // Data arrives in WB
    @(negedge clk);
    check_value("weight load we", 32'(regfile_we_wb_o), 32'd1);
    check_value("weight load waddr", 32'(regfile_waddr_wb_o), 32'd5);
    check_value("weight load data", regfile_wdata_wb_o, weight_val);
    @(posedge clk);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= 6'd9;
    lsu_tospra_ex_i <= {1'b1, 1'b1};   // Activation SPR 1
    lsu_rdata_i     <= '0;
    @(posedge clk);
    idle_inputs();
    lsu_rdata_i <= act_val;
    @(negedge clk);
    check_value("act load we", 32'(regfile_we_wb_o), 32'd1);
    check_value("act load waddr", 32'(regfile_waddr_wb_o), 32'd9);
    check_value("act load data", regfile_wdata_wb_o, act_val);
    @(posedge clk);
    idle_inputs();
    mult_en_i         <= 1'b1;
    mult_operator_i   <= MULT_DOT8;
    mult_operand_c_i  <= c;
    dot_spr_operand_i <= 1'b1;
    lsu_tosprw_ex_i   <= {2'd2, 1'b0};   // Read only, no write bit
    lsu_tospra_ex_i   <= {1'b1, 1'b0};
    @(posedge clk);
    idle_inputs();
    @(negedge clk);
    check_value("spr dot8", regfile_wdata_wb_o, dot_ref(1'b1, act_val, weight_val, c));
  endtask

  task automatic test_load_compute();
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] c;
    a = $urandom;
    b = $urandom;
    c = $urandom;
    @(posedge clk);
    idle_inputs();
    alu_en_i          <= 1'b1;
    alu_operand_a_i   <= a;
    alu_operand_b_i   <= b;
    mult_en_i         <= 1'b1;
    mult_operator_i   <= MULT_DOT16;
    mult_operand_c_i  <= c;
    dot_spr_operand_i <= 1'b1;
    lsu_tosprw_ex_i   <= {2'd2, 1'b0};
    lsu_tospra_ex_i   <= {1'b1, 1'b0};
    lsu_en_i          <= 1'b1;
    regfile_we_i      <= 1'b1;
    regfile_waddr_i   <= 6'd17;
    @(negedge clk);
    check_value("load-compute fw", regfile_alu_wdata_fw_o, alu_ref(ALU_ADD, a, b));
    check_value("vliw flag", 32'(compute_load_vliw_o), 32'd1);
    @(posedge clk);
    idle_inputs();
    lsu_rdata_i <= $urandom;   // Must not reach the WB data
    @(negedge clk);
    check_value("load-compute we", 32'(regfile_we_wb_o), 32'd1);
    check_value("load-compute waddr", 32'(regfile_waddr_wb_o), 32'd17);
    check_value("load-compute wb data", regfile_wdata_wb_o,
                dot_ref(1'b0, act_val, weight_val, c));
  endtask

  task automatic test_backpressure();
    logic [xlen-1:0] d;
    d = $urandom;
    @(posedge clk);
    idle_inputs();
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= 6'd33;
    @(posedge clk);
    wb_ready_i      <= 1'b0;   // WB stalls with a new load waiting
    regfile_waddr_i <= 6'd40;
    lsu_rdata_i     <= d;
    @(negedge clk);
    check_value("stall ex_valid", 32'(ex_valid_o), 32'd0);
    check_value("stall ex_ready", 32'(ex_ready_o), 32'd0);
    check_value("stall we", 32'(regfile_we_wb_o), 32'd1);
    check_value("stall data", regfile_wdata_wb_o, d);
    @(negedge clk);
    check_value("held we", 32'(regfile_we_wb_o), 32'd1);
    check_value("held waddr", 32'(regfile_waddr_wb_o), 32'd33);
    @(posedge clk);
    wb_ready_i <= 1'b1;
    lsu_err_i  <= 1'b1;
    @(negedge clk);
    check_value("err accept", 32'(ex_valid_o), 32'd1);
    @(posedge clk);
    idle_inputs();
    @(negedge clk);
    check_value("we after err", 32'(regfile_we_wb_o), 32'd0);
    check_value("waddr after err", 32'(regfile_waddr_wb_o), 32'd33);
    @(posedge clk);
    branch_in_ex_i <= 1'b1;
    alu_en_i       <= 1'b1;
    lsu_ready_ex_i <= 1'b0;
    wb_ready_i     <= 1'b0;
    @(negedge clk);
    check_value("branch ex_ready", 32'(ex_ready_o), 32'd1);
    check_value("branch ex_valid", 32'(ex_valid_o), 32'd0);
    @(posedge clk);
    idle_inputs();
  endtask

  initial begin
    void'($urandom(32'hf89b4f5a));
    rst_n = 1'b0;
    idle_inputs();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("we after reset", 32'(regfile_we_wb_o), 32'd0);
    test_alu_ops();
    test_mult_ops();
    test_spr_load();
    test_load_compute();
    test_backpressure();
    @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* filelist.f */
common/ex_pkg.sv
common/rnn_pkg.sv
source/ex_alu.sv
mult/ex_mult.sv
source/rnn_spr_file.sv
source/ex_writeback.sv
source/ex_stage.sv
verification/ex_stage_chk.sv
verification/tb_ex_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the EX stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_stage \
  -f filelist.f \
  --Mdir obj_dir -o sim_ex_stage

./obj_dir/sim_ex_stage
